/* axi_reg_top.f */
design/axi_regs_pkg.sv
design/axi4_lite_if.sv
design/reg_bank_if.sv
design/axi4_lite_slave.sv
design/reg_bank.sv
design/axi_reg_top.sv
verification/axi_reg_tb.sv

/* design/axi4_lite_if.sv */
`timescale 1ns/1ps

interface axi4_lite_if;

    // write address channel
    axi_regs_pkg::addr_t awaddr;
    logic                awvalid;
    logic                awready;

    // write data channel
    axi_regs_pkg::data_t wdata;
    axi_regs_pkg::strb_t wstrb;
    logic                wvalid;
    logic                wready;

    // write response channel
    axi_regs_pkg::resp_t bresp;
    logic                bvalid;
    logic                bready;

    // read address channel
    axi_regs_pkg::addr_t araddr;
    logic                arvalid;
    logic                arready;

    // read data channel
    axi_regs_pkg::data_t rdata;
    axi_regs_pkg::resp_t rresp;
    logic                rvalid;
    logic                rready;

    modport master (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    modport slave (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

/* design/axi4_lite_slave.sv */
`timescale 1ns/1ps

module axi4_lite_slave #(
    parameter int REG_COUNT = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    axi4_lite_if.slave axi,
    reg_bank_if.ctrl   regs
);

    localparam int IDX_W = $clog2(REG_COUNT);

    // first byte address past the register window
    localparam axi_regs_pkg::addr_t WINDOW_END = axi_regs_pkg::addr_t'(4 * REG_COUNT);

    typedef enum logic [1:0] {
        W_IDLE,
        W_DATA,
        W_RESP
    } write_state_t;

    typedef enum logic {
        R_IDLE,
        R_DATA
    } read_state_t;

    write_state_t w_state;
    write_state_t w_next;
    read_state_t  r_state;
    read_state_t  r_next;

    axi_regs_pkg::addr_t wr_addr;
    axi_regs_pkg::addr_t rd_addr;
    axi_regs_pkg::data_t rd_word;

    logic wr_ok;
    logic rd_ok;
    logic aw_xfer;
    logic w_xfer;
    logic b_xfer;
    logic ar_xfer;
    logic r_xfer;

    // aligned and inside the window
    function automatic logic addr_in_window(axi_regs_pkg::addr_t addr);
        return (addr < WINDOW_END) && (addr[1:0] == 2'b00);
    endfunction

    assign aw_xfer = axi.awvalid && axi.awready;
    assign w_xfer  = axi.wvalid && axi.wready;
    assign b_xfer  = axi.bvalid && axi.bready;
    assign ar_xfer = axi.arvalid && axi.arready;
    assign r_xfer  = axi.rvalid && axi.rready;

    // write channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_state <= W_IDLE;
        end else begin
            w_state <= w_next;
        end
    end

    always_comb begin
        w_next = w_state;
        case (w_state)
            W_IDLE: begin
                if (aw_xfer) begin
                    w_next = W_DATA;
                end
            end
            W_DATA: begin
                if (w_xfer) begin
                    w_next = W_RESP;
                end
            end
            W_RESP: begin
                if (b_xfer) begin
                    w_next = W_IDLE;
                end
            end
            default: w_next = W_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_addr <= '0;
        end else if (aw_xfer) begin
            wr_addr <= axi.awaddr;
        end
    end

    assign wr_ok = addr_in_window(wr_addr);

    assign axi.awready = (w_state == W_IDLE);
    assign axi.wready  = (w_state == W_DATA);
    assign axi.bvalid  = (w_state == W_RESP);
    // wr_addr is stable from W_DATA through W_RESP, so bresp holds too
    assign axi.bresp   = wr_ok ? axi_regs_pkg::RESP_OKAY : axi_regs_pkg::RESP_SLVERR;

    // bad address drops the write
    assign regs.wr_en    = w_xfer && wr_ok;
    assign regs.wr_index = wr_addr[IDX_W+1:2];
    assign regs.wr_data  = axi.wdata;
    assign regs.wr_strb  = axi.wstrb;

    // read channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_state <= R_IDLE;
        end else begin
            r_state <= r_next;
        end
    end

    always_comb begin
        r_next = r_state;
        case (r_state)
            R_IDLE: begin
                if (ar_xfer) begin
                    r_next = R_DATA;
                end
            end
            R_DATA: begin
                if (r_xfer) begin
                    r_next = R_IDLE;
                end
            end
            default: r_next = R_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else if (ar_xfer) begin
            rd_addr <= axi.araddr;
        end
    end

    // snapshot taken on the ar edge; a write on that same edge is not seen
    assign regs.rd_index = axi.araddr[IDX_W+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_word <= '0;
        end else if (ar_xfer) begin
            rd_word <= regs.rd_data;
        end
    end

    assign rd_ok = addr_in_window(rd_addr);

    assign axi.arready = (r_state == R_IDLE);
    assign axi.rvalid  = (r_state == R_DATA);
    assign axi.rresp   = rd_ok ? axi_regs_pkg::RESP_OKAY : axi_regs_pkg::RESP_SLVERR;
    assign axi.rdata   = (axi.rvalid && rd_ok) ? rd_word : '0;

endmodule

/* design/axi_reg_top.sv */
`timescale 1ns/1ps

module axi_reg_top #(
    parameter int REG_COUNT = 16
) (
    input  logic                clk,
    input  logic                rst_n,

    // write address
    input  axi_regs_pkg::addr_t awaddr,
    input  logic                awvalid,
    output logic                awready,

    // write data
    input  axi_regs_pkg::data_t wdata,
    input  axi_regs_pkg::strb_t wstrb,
    input  logic                wvalid,
    output logic                wready,

    // write response
    output axi_regs_pkg::resp_t bresp,
    output logic                bvalid,
    input  logic                bready,

    // read address
    input  axi_regs_pkg::addr_t araddr,
    input  logic                arvalid,
    output logic                arready,

    // read data
    output axi_regs_pkg::data_t rdata,
    output axi_regs_pkg::resp_t rresp,
    output logic                rvalid,
    input  logic                rready
);

    axi4_lite_if axi_bus ();

    reg_bank_if #(
        .REG_COUNT (REG_COUNT)
    ) reg_bus ();

    // master side comes straight from the pins
    assign axi_bus.awaddr  = awaddr;
    assign axi_bus.awvalid = awvalid;
    assign axi_bus.wdata   = wdata;
    assign axi_bus.wstrb   = wstrb;
    assign axi_bus.wvalid  = wvalid;
    assign axi_bus.bready  = bready;
    assign axi_bus.araddr  = araddr;
    assign axi_bus.arvalid = arvalid;
    assign axi_bus.rready  = rready;

    assign awready = axi_bus.awready;
    assign wready  = axi_bus.wready;
    assign bresp   = axi_bus.bresp;
    assign bvalid  = axi_bus.bvalid;
    assign arready = axi_bus.arready;
    assign rdata   = axi_bus.rdata;
    assign rresp   = axi_bus.rresp;
    assign rvalid  = axi_bus.rvalid;

    axi4_lite_slave #(
        .REG_COUNT (REG_COUNT)
    ) i_slave (
        .clk   (clk),
        .rst_n (rst_n),
        .axi   (axi_bus.slave),
        .regs  (reg_bus.ctrl)
    );

    reg_bank #(
        .REG_COUNT (REG_COUNT)
    ) i_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .regs  (reg_bus.bank)
    );

endmodule

/* design/axi_regs_pkg.sv */
package axi_regs_pkg;

    // bus byte address
    typedef logic [31:0] addr_t;

    // register and bus data word
    typedef logic [31:0] data_t;

    // one strobe bit per data byte
    typedef logic [3:0] strb_t;

    typedef logic [1:0] resp_t;

    // response codes, same on b and r channels
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

/* design/reg_bank.sv */
`timescale 1ns/1ps

module reg_bank #(
    parameter int REG_COUNT = 16
) (
    input  logic     clk,
    input  logic     rst_n,
    reg_bank_if.bank regs
);

    axi_regs_pkg::data_t mem [REG_COUNT];

    // byte lanes follow wr_strb
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                mem[i] <= '0;
            end
        end else if (regs.wr_en) begin
            for (int b = 0; b < $bits(axi_regs_pkg::strb_t); b++) begin
                if (regs.wr_strb[b]) begin
                    mem[regs.wr_index][b*8 +: 8] <= regs.wr_data[b*8 +: 8];
                end
            end
        end
    end

    // asynchronous read
    assign regs.rd_data = mem[regs.rd_index];

endmodule

/* design/reg_bank_if.sv */
`timescale 1ns/1ps

interface reg_bank_if #(
    parameter int REG_COUNT = 16
);

    localparam int IDX_W = $clog2(REG_COUNT);

    // write port, one strobed word per cycle
    logic                wr_en;
    logic [IDX_W-1:0]    wr_index;
    axi_regs_pkg::data_t wr_data;
    axi_regs_pkg::strb_t wr_strb;

    // read port
    logic [IDX_W-1:0]    rd_index;
    axi_regs_pkg::data_t rd_data;

    modport ctrl (
        output wr_en, wr_index, wr_data, wr_strb, rd_index,
        input  rd_data
    );

    modport bank (
        input  wr_en, wr_index, wr_data, wr_strb, rd_index,
        output rd_data
    );

endinterface

/* run.sh */
#!/usr/bin/env bash
# build and run the register block testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module axi_reg_tb -f axi_reg_top.f \
    && ./obj_dir/Vaxi_reg_tb | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verification/axi_reg_tb.sv */
`timescale 1ns/1ps

module axi_reg_tb;

    localparam int REG_COUNT = 16;
    localparam int IDX_W = $clog2(REG_COUNT);
    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 5;
    localparam int RANDOM_N = 200;
    // reset reads, fill and read back, partial, bad addresses, back-pressure, random
    localparam int NUM_OPS = 3 * REG_COUNT + 16 + 18 + 16 + RANDOM_N;
    localparam int WATCHDOG_NS = (NUM_OPS * 40 + RESET_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        axi_regs_pkg::addr_t addr;
        axi_regs_pkg::resp_t resp;
        axi_regs_pkg::data_t data;
    } expect_t;

    logic clk = 1'b0;
    logic rst_n;
    axi_regs_pkg::addr_t awaddr, araddr;
    axi_regs_pkg::data_t wdata, rdata;
    axi_regs_pkg::strb_t wstrb;
    axi_regs_pkg::resp_t bresp, rresp;
    logic awvalid, wvalid, bready, arvalid, rready;
    logic awready, wready, bvalid, arready, rvalid;

    axi_regs_pkg::data_t model [REG_COUNT];
    expect_t exp_b [$];
    expect_t exp_r [$];
    integer seed = 32'h0fe36e2d;
    int errors = 0;
    int seq_errors = 0;
    int checks = 0;
    logic b_hold, r_hold;
    expect_t b_last, r_last;

    axi_reg_top #(.REG_COUNT(REG_COUNT)) i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'({1'b0, r[30:0]} % n);
    endfunction

    // writes update the model, reads return from it
    function automatic expect_t expected_access(input logic is_write,
                                                input axi_regs_pkg::addr_t addr,
                                                input axi_regs_pkg::data_t data,
                                                input axi_regs_pkg::strb_t strb);
        expect_t e;
        logic [IDX_W-1:0] idx;
        axi_regs_pkg::data_t mask;
        e.addr = addr;
        e.resp = axi_regs_pkg::RESP_SLVERR;
        e.data = '0;
        idx = addr[IDX_W+1:2];
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        if ((addr >> 2) < REG_COUNT && addr[1:0] == 2'b00) begin
            e.resp = axi_regs_pkg::RESP_OKAY;
            if (is_write) begin
                model[idx] = (model[idx] & ~mask) | (data & mask);
            end else begin
                e.data = model[idx];
            end
        end
        return e;
    endfunction

    task automatic axi_write(input axi_regs_pkg::addr_t addr, input axi_regs_pkg::data_t data,
                             input axi_regs_pkg::strb_t strb, input int max_wait);
        int aw_dly;
        int w_dly;
        int b_dly;
        exp_b.push_back(expected_access(1'b1, addr, data, strb));
        aw_dly = rand_below(5);
        w_dly = rand_below(5);
        b_dly = rand_below(max_wait + 1);
        fork
            begin
                repeat (aw_dly) @(posedge clk);
                awaddr <= addr;
                awvalid <= 1'b1;
                do @(posedge clk); while (!awready);
                awvalid <= 1'b0;
            end
            begin
                // w may come first and waits for W_DATA
                repeat (w_dly) @(posedge clk);
                wdata <= data;
                wstrb <= strb;
                wvalid <= 1'b1;
                do @(posedge clk); while (!wready);
                wvalid <= 1'b0;
            end
        join
        do @(posedge clk); while (!bvalid);
        repeat (b_dly) @(posedge clk);
        bready <= 1'b1;
        do @(posedge clk); while (!bvalid);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input axi_regs_pkg::addr_t addr, input int max_wait);
        int r_dly;
        exp_r.push_back(expected_access(1'b0, addr, '0, '0));
        r_dly = rand_below(max_wait + 1);
        repeat (rand_below(3)) @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        do @(posedge clk); while (!rvalid);
        repeat (r_dly) @(posedge clk);
        rready <= 1'b1;
        do @(posedge clk); while (!rvalid);
        rready <= 1'b0;
    endtask

    // compare at each transfer, and check held responses under back-pressure
    always @(posedge clk) begin : response_check
        expect_t e;
        if (rst_n !== 1'b1) begin
            b_hold = 1'b0;
            r_hold = 1'b0;
        end else begin
            if (b_hold && (bvalid !== 1'b1 || bresp !== b_last.resp)) begin
                errors++;
                $display("Mismatch at %0t: write response moved while stalled, bvalid %b bresp %b",
                         $time, bvalid, bresp);
            end
            if (r_hold && (rvalid !== 1'b1 || rresp !== r_last.resp || rdata !== r_last.data)) begin
                errors++;
                $display("Mismatch at %0t: read response moved while stalled, rresp %b rdata %h",
                         $time, rresp, rdata);
            end
            if (bvalid && bready) begin
                checks++;
                if (exp_b.size() == 0) begin
                    errors++;
                    $display("write response at %0t with no write in flight", $time);
                end else begin
                    e = exp_b.pop_front();
                    if (bresp !== e.resp) begin
                        errors++;
                        $display("Mismatch at %0t: write to %h gave bresp %b, expected %b",
                                 $time, e.addr, bresp, e.resp);
                    end
                end
            end
            if (rvalid && rready) begin
                checks++;
                if (exp_r.size() == 0) begin
                    errors++;
                    $display("read response at %0t with no read in flight", $time);
                end else begin
                    e = exp_r.pop_front();
                    if (rresp !== e.resp || rdata !== e.data) begin
                        errors++;
                        $display("Mismatch at %0t: read of %h gave %b/%h, expected %b/%h",
                                 $time, e.addr, rresp, rdata, e.resp, e.data);
                    end
                end
            end
            b_hold = bvalid && !bready;
            r_hold = rvalid && !rready;
            b_last.resp = bresp;
            r_last.resp = rresp;
            r_last.data = rdata;
        end
    end

    initial begin : stimulus
        axi_regs_pkg::addr_t addr;
        model = '{default: '0};
        rst_n <= 1'b0;
        awaddr <= '0;
        awvalid <= 1'b0;
        wdata <= '0;
        wstrb <= '0;
        wvalid <= 1'b0;
        bready <= 1'b0;
        araddr <= '0;
        arvalid <= 1'b0;
        rready <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (bvalid !== 1'b0 || rvalid !== 1'b0 || wready !== 1'b0 || awready !== 1'b1
                || arready !== 1'b1) begin
            seq_errors++;
            $display("Mismatch at %0t: after reset aw/w/b/ar/r = %b%b%b%b%b, expected 10010",
                     $time, awready, wready, bvalid, arready, rvalid);
        end
        for (int i = 0; i < REG_COUNT; i++) begin
            axi_read(axi_regs_pkg::addr_t'(4 * i), 3);
        end
        for (int i = 0; i < REG_COUNT; i++) begin
            axi_write(axi_regs_pkg::addr_t'(4 * i), axi_regs_pkg::data_t'($random(seed)), 4'hf, 3);
        end
        for (int i = 0; i < REG_COUNT; i++) begin
            axi_read(axi_regs_pkg::addr_t'(4 * i), 3);
        end
        // partial strobes
        for (int i = 0; i < 8; i++) begin
            addr = axi_regs_pkg::addr_t'(4 * rand_below(REG_COUNT));
            axi_write(addr, axi_regs_pkg::data_t'($random(seed)),
                      axi_regs_pkg::strb_t'(rand_below(15) + 1), 3);
            axi_read(addr, 3);
        end
        // out of window, then misaligned
        for (int i = 0; i < 6; i++) begin
            if (i % 2 == 0) begin
                addr = axi_regs_pkg::addr_t'(4 * REG_COUNT + 4 * rand_below(64));
            end else begin
                addr = axi_regs_pkg::addr_t'(4 * rand_below(REG_COUNT) + 1 + rand_below(3));
            end
            axi_write(addr, axi_regs_pkg::data_t'($random(seed)), 4'hf, 3);
            axi_read(addr, 3);
            axi_read(addr & axi_regs_pkg::addr_t'(4 * REG_COUNT - 4), 3);
        end
        // long ready-low stretches
        for (int i = 0; i < 8; i++) begin
            addr = axi_regs_pkg::addr_t'(4 * rand_below(REG_COUNT));
            axi_write(addr, axi_regs_pkg::data_t'($random(seed)), 4'hf, 15);
            axi_read(addr, 15);
        end
        for (int i = 0; i < RANDOM_N; i++) begin
            if (rand_below(4) == 0) begin
                addr = axi_regs_pkg::addr_t'(rand_below(8 * REG_COUNT));
            end else begin
                addr = axi_regs_pkg::addr_t'(4 * rand_below(REG_COUNT));
            end
            if (rand_below(2) == 0) begin
                axi_write(addr, axi_regs_pkg::data_t'($random(seed)),
                          axi_regs_pkg::strb_t'(rand_below(16)), 4);
            end else begin
                axi_read(addr, 4);
            end
        end
        repeat (2) @(posedge clk);
        if (exp_b.size() != 0 || exp_r.size() != 0) begin
            seq_errors++;
            $display("responses still outstanding at the end of the run");
        end
        $display("checks %0d, response errors %0d, other errors %0d", checks, errors, seq_errors);
        if (errors == 0 && seq_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns without finishing", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
